/* rtl/scaler_consts.svh */
`ifndef SCALER_CONSTS_SVH
`define SCALER_CONSTS_SVH

// Pixel sample width
`define PIX_W       12

// Coefficient magnitude width, unity gain sits at bit COE_W-2
`define COE_W       10
`define COE_SHIFT   8     // Log2 of unity coefficient (256)

// Step and position format, 4.12 unsigned
`define STEP_W      16
`define FRAC_W      12    // Fraction bits of step and position
`define STEP_ONE    4096  // Step of 1.000

`define POS_W       24    // Line position counters

// Phase index taken from position bits FRAC_W-1 down to 2
`define PHASE_W     10

`define ROUND_BIT   7     // Half LSB of the scaled-down sum

`endif

/* rtl/scaler_pkg.sv */
`default_nettype none

`include "scaler_consts.svh"

package scaler_pkg;

    // One pixel of the raster stream with its level strobes
    typedef struct packed {
        logic [`PIX_W-1:0] data;
        logic              de;    // Valid pixel
        logic              hs;    // First pixel of a line
        logic              vs;    // First pixel of a frame
    } pix_stream_t;

    // Kernel weights for one phase, all stored as magnitudes
    typedef struct packed {
        logic [`COE_W-1:0] c0;    // Subtracted
        logic [`COE_W-1:0] c1;
        logic [`COE_W-1:0] c2;
        logic [`COE_W-1:0] c3;    // Subtracted
    } coe_set_t;

    // Window taps, the window shifts from left (newest) to right (oldest)
    typedef enum logic [1:0] {
        TAP_FAR_L  = 2'd0,
        TAP_NEAR_L = 2'd1,
        TAP_NEAR_R = 2'd2,
        TAP_FAR_R  = 2'd3
    } tap_phase_e;

endpackage

`default_nettype wire

/* rtl/cubic_table.sv */
`default_nettype none
`timescale 1ns/1ps

`include "scaler_consts.svh"

module cubic_table (
    input  wire                       clk,
    input  wire  [`PHASE_W-1:0]       phase_i,
    output scaler_pkg::coe_set_t      coe_o
);

    import scaler_pkg::*;

    localparam int TAB_N = 1 << `PHASE_W;

    logic [`COE_W-1:0] c0_rom [TAB_N];
    logic [`COE_W-1:0] c1_rom [TAB_N];
    logic [`COE_W-1:0] c2_rom [TAB_N];
    logic [`COE_W-1:0] c3_rom [TAB_N];

    // Keys cubic with a = -0.5, inner segment for distance d below one
    function automatic real cubic_near(input real d);
        return 1.5 * d * d * d - 2.5 * d * d + 1.0;
    endfunction

    // Weight magnitudes for phase idx, the output lies between the near
    // taps at fraction t measured from TAP_NEAR_R
    function automatic coe_set_t kernel_set(input int idx);
        real      t;
        real      w [4];
        coe_set_t set;
        t = real'(idx) / real'(TAB_N);
        w[TAP_FAR_L]  = 0.5 * t * t * (1.0 - t);          // Distance 2-t
        w[TAP_NEAR_L] = cubic_near(1.0 - t);
        w[TAP_NEAR_R] = cubic_near(t);
        w[TAP_FAR_R]  = 0.5 * t * (1.0 - t) * (1.0 - t);  // Distance 1+t
        set.c0 = `COE_W'($rtoi(w[TAP_FAR_L] * real'(1 << `COE_SHIFT) + 0.5));
        set.c2 = `COE_W'($rtoi(w[TAP_NEAR_R] * real'(1 << `COE_SHIFT) + 0.5));
        set.c3 = `COE_W'($rtoi(w[TAP_FAR_R] * real'(1 << `COE_SHIFT) + 0.5));
        // Near-left takes up the rounding error so each phase has unity gain
        set.c1 = `COE_W'((1 << `COE_SHIFT) + set.c0 + set.c3 - set.c2);
        return set;
    endfunction

    initial begin
        coe_set_t set;
        for (int i = 0; i < TAB_N; i++) begin
            set = kernel_set(i);
            c0_rom[i] = set.c0;
            c1_rom[i] = set.c1;
            c2_rom[i] = set.c2;
            c3_rom[i] = set.c3;
        end
    end

    always_ff @(posedge clk) begin
        coe_o.c0 <= c0_rom[phase_i];
        coe_o.c1 <= c1_rom[phase_i];
        coe_o.c2 <= c2_rom[phase_i];
        coe_o.c3 <= c3_rom[phase_i];
    end

endmodule

`default_nettype wire

/* rtl/scaler_h.sv */
`default_nettype none
`timescale 1ns/1ps

`include "scaler_consts.svh"

module scaler_h (
    input  wire                       clk,
    input  wire                       rst_i,
    input  wire  [`STEP_W-1:0]        step_i,
    input  wire  scaler_pkg::pix_stream_t pix_i,
    output logic [`PHASE_W-1:0]       phase_o,
    input  wire  scaler_pkg::coe_set_t coe_i,
    output scaler_pkg::pix_stream_t   pix_o
);

    import scaler_pkg::*;

    localparam int MUL_W   = `COE_W + `PIX_W;
    localparam int OVF_LSB = `COE_SHIFT + `PIX_W;

    localparam logic [MUL_W+1:0] RND_ADD = (MUL_W + 2)'(1 << `ROUND_BIT);

    typedef struct packed {
        logic de;
        logic hs;
        logic vs;
    } strobe_t;

    logic [`STEP_W-1:0] step_act;     // Step in force for the current frame
    logic [`POS_W-1:0]  cnt_i;        // Input position, 4.12 per pixel
    logic [`POS_W-1:0]  cnt_o;        // Next output position
    logic               line_pend;
    logic               frame_pend;
    logic               fire;

    logic [`PIX_W-1:0]  win [4];      // Tap window
    logic [`PIX_W-1:0]  opd [4];      // Frozen at the output decision
    logic [`PIX_W-1:0]  tap_q [4];    // Aligned with coe_i

    logic [MUL_W-1:0]   prod [4];
    logic signed [MUL_W+1:0] sum;

    strobe_t dec;
    strobe_t dly [3];

    function automatic logic [`COE_W-1:0] coe_at(input coe_set_t set,
                                                  input tap_phase_e tap);
        case (tap)
            TAP_FAR_L:  return set.c0;
            TAP_NEAR_L: return set.c1;
            TAP_NEAR_R: return set.c2;
            default:    return set.c3;
        endcase
    endfunction

    // An output pixel is due once the input has moved past its position
    assign fire = cnt_i > cnt_o;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            step_act   <= `STEP_W'(`STEP_ONE);
            cnt_i      <= '0;
            cnt_o      <= '0;
            line_pend  <= 1'b0;
            frame_pend <= 1'b0;
            dec        <= '0;
        end else begin
            dec <= '0;

            if (pix_i.de) begin
                cnt_i <= cnt_i + `POS_W'(`STEP_ONE);
            end

            if (fire) begin
                dec.de     <= 1'b1;
                dec.hs     <= line_pend;
                dec.vs     <= frame_pend;
                line_pend  <= 1'b0;
                frame_pend <= 1'b0;
                cnt_o      <= cnt_o + `POS_W'(step_act);
            end

            // Line start restarts both positions, output 0 sits on pixel 0
            if (pix_i.de && pix_i.hs) begin
                cnt_i     <= '0;
                cnt_o     <= `POS_W'(`STEP_ONE);
                line_pend <= 1'b1;
            end

            if (pix_i.de && pix_i.vs) begin
                frame_pend <= 1'b1;
                step_act   <= step_i;     // Held for the whole frame
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pix_i.de) begin
            win[TAP_FAR_L]  <= pix_i.data;
            win[TAP_NEAR_L] <= win[TAP_FAR_L];
            win[TAP_NEAR_R] <= win[TAP_NEAR_L];
            win[TAP_FAR_R]  <= win[TAP_NEAR_R];
        end

        if (fire) begin
            opd[TAP_FAR_L]  <= win[TAP_FAR_L];
            opd[TAP_NEAR_L] <= win[TAP_NEAR_L];
            opd[TAP_NEAR_R] <= win[TAP_NEAR_R];
            // Oldest tap still holds the previous line near the start
            opd[TAP_FAR_R]  <= (cnt_i <= `POS_W'(2 * `STEP_ONE)) ? '0 : win[TAP_FAR_R];
            phase_o         <= cnt_o[`FRAC_W-1 -: `PHASE_W];
        end

        tap_q <= opd;                     // Table needs one clock for phase_o

        for (int k = 0; k < 4; k++) begin
            prod[k] <= coe_at(coe_i, tap_phase_e'(k)) * tap_q[k];
        end

        sum <= $signed({2'b00, prod[TAP_NEAR_L]})
             + $signed({2'b00, prod[TAP_NEAR_R]})
             - $signed({2'b00, prod[TAP_FAR_L]})
             - $signed({2'b00, prod[TAP_FAR_R]})
             + $signed(RND_ADD);
    end

    // Strobes follow the table, multiply and sum stages
    always_ff @(posedge clk) begin
        if (rst_i) begin
            dly   <= '{default: '0};
            pix_o <= '0;
        end else begin
            dly[0] <= dec;
            dly[1] <= dly[0];
            dly[2] <= dly[1];

            pix_o.de <= dly[2].de;
            pix_o.hs <= dly[2].hs;
            pix_o.vs <= dly[2].vs;

            if (dly[2].de) begin
                if (sum[MUL_W+1]) begin
                    pix_o.data <= '0;         // Undershoot
                end else if (|sum[MUL_W:OVF_LSB]) begin
                    pix_o.data <= '1;         // Overshoot
                end else begin
                    pix_o.data <= sum[`COE_SHIFT +: `PIX_W];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/scaler_top.sv */
`default_nettype none
`timescale 1ns/1ps

`include "scaler_consts.svh"

module scaler_top (
    input  wire                       clk,
    input  wire                       rst_i,
    input  wire  [`STEP_W-1:0]        step_i,
    input  wire  scaler_pkg::pix_stream_t pix_i,
    output scaler_pkg::pix_stream_t   pix_o
);

    import scaler_pkg::*;

    logic [`PHASE_W-1:0] phase;       // Resampler to table
    coe_set_t            coe;         // Table to resampler, one clock later

    scaler_h u_scaler_h (
        .clk     (clk),
        .rst_i   (rst_i),
        .step_i  (step_i),
        .pix_i   (pix_i),
        .phase_o (phase),
        .coe_i   (coe),
        .pix_o   (pix_o)
    );

    cubic_table u_cubic_table (
        .clk     (clk),
        .phase_i (phase),
        .coe_o   (coe)
    );

endmodule

`default_nettype wire

/* tests/scaler_checker.sv */
`default_nettype none
`timescale 1ns/1ps

module scaler_checker (
    input wire                          clk,
    input wire                          rst_i,
    input wire scaler_pkg::pix_stream_t pix_in_i,
    input wire scaler_pkg::pix_stream_t pix_out_i
);

    logic        line_seen;         // First input line has started
    int unsigned fail_cnt = 0;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            line_seen <= 1'b0;
        end else if (pix_in_i.de && pix_in_i.hs) begin
            line_seen <= 1'b1;
        end
    end

    reset_clears_output: assert property (@(posedge clk) rst_i |=> (pix_out_i == '0))
        else begin
            fail_cnt++;
            $error("Output stream not cleared after reset");
        end

    idle_before_input: assert property (@(posedge clk) disable iff (rst_i)
        !line_seen |-> !(pix_out_i.de || pix_out_i.hs || pix_out_i.vs))
        else begin
            fail_cnt++;
            $error("Output strobe before the first input line");
        end

    // Line start only on a valid pixel, frame start only on a line start
    hs_with_de: assert property (@(posedge clk) disable iff (rst_i)
        pix_out_i.hs |-> pix_out_i.de)
        else begin
            fail_cnt++;
            $error("Output line start without data enable");
        end

    vs_with_hs: assert property (@(posedge clk) disable iff (rst_i)
        pix_out_i.vs |-> pix_out_i.hs)
        else begin
            fail_cnt++;
            $error("Output frame start without line start");
        end

endmodule

bind scaler_top scaler_checker u_checker (
    .clk       (clk),
    .rst_i     (rst_i),
    .pix_in_i  (pix_i),
    .pix_out_i (pix_o)
);

`default_nettype wire

/* tests/scaler_tb.sv */
`default_nettype none
`timescale 1ns/1ps

`include "scaler_consts.svh"

module scaler_tb;

    import scaler_pkg::*;

    localparam int N_MIN    = 16;
    localparam int N_MAX    = 47;
    localparam int N_FRAMES = 6;
    localparam int LINES_PF = 4;
    localparam int RST_CYC  = 16;
    // Pixels, blanking up to 2*N_MAX outputs plus slack
    localparam int LINE_CYC = 3 * N_MAX + 16;
    localparam int TIMEOUT  = RST_CYC + N_FRAMES * LINES_PF * LINE_CYC + 200;
    localparam logic [31:0] SEED = 32'h1ef7;

    localparam logic [`PIX_W-1:0] PIX_FULL = '1;

    localparam int STEPS   [N_FRAMES] = '{4096, 2048, 6144, 4096, 6144, 2048};
    localparam bit EDGE    [N_FRAMES] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1};
    localparam bit MID_CHG [N_FRAMES] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};

    typedef struct packed {
        int                k;       // Output pixels due for this line
        int                step;
        int                edge_at; // First full-scale pixel of an edge line
        logic [`PIX_W-1:0] val;
        logic              is_edge;
        logic              first;   // Line opens a frame
    } line_exp_t;

    logic               clk;
    logic               rst_i;
    logic [`STEP_W-1:0] step_i;
    pix_stream_t        pix_i;
    pix_stream_t        pix_o;

    line_exp_t lines_q [$];
    line_exp_t cur;
    int        idx        = 0;
    int        lines_seen = 0;
    bit        active     = 1'b0;
    int        cycles     = 0;

    scaler_top DUT (
        .clk    (clk),
        .rst_i  (rst_i),
        .step_i (step_i),
        .pix_i  (pix_i),
        .pix_o  (pix_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_failed();
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic abort_with(input string why);
        $display("Error: %s", why);
        stop_failed();
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
        stop_failed();
    endtask

    // Count of j >= 0 with one plus j steps short of the last input pixel
    function automatic int expected_count(input int n, input int step);
        int k;
        k = 0;
        while (`STEP_ONE + k * step < (n - 1) * `STEP_ONE) begin
            k++;
        end
        return k;
    endfunction

    task automatic send_line(input bit is_edge, input bit first, input int step);
        int        n;
        int        blank;
        line_exp_t e;
        n         = N_MIN + int'($urandom_range(N_MAX - N_MIN));
        e.k       = expected_count(n, step);
        e.step    = step;
        e.edge_at = n / 2;
        e.val     = `PIX_W'($urandom);
        e.is_edge = is_edge;
        e.first   = first;
        lines_q.push_back(e);
        for (int p = 0; p < n; p++) begin
            @(posedge clk);
            if (is_edge) begin
                pix_i.data <= (p >= e.edge_at) ? PIX_FULL : '0;
            end else begin
                pix_i.data <= e.val;
            end
            pix_i.de <= 1'b1;
            pix_i.hs <= (p == 0);
            pix_i.vs <= (p == 0) && first;
        end
        @(posedge clk);
        pix_i <= '0;
        blank = e.k + 4 + int'($urandom_range(8));  // Blanking covers the line's outputs
        repeat (blank) @(posedge clk);
    endtask

    task automatic send_frame(input int f);
        for (int l = 0; l < LINES_PF; l++) begin
            if (MID_CHG[f] && l == 1) begin
                step_i <= `STEP_W'(STEPS[f + 1]); // Must wait for the next frame
            end
            send_line(EDGE[f], l == 0, STEPS[f]);
        end
    endtask

    task automatic check_output();
        int pos;
        if (pix_o.hs) begin
            if (active) begin
                assert (idx == cur.k) else report_mismatch("pix_o.de count", idx, cur.k);
            end
            if (lines_q.size() == 0) begin
                abort_with("Output line start with no input line left");
            end
            cur        = lines_q.pop_front();
            idx        = 0;
            active     = 1'b1;
            lines_seen = lines_seen + 1;
            assert (pix_o.vs == cur.first) else report_mismatch("pix_o.vs", pix_o.vs, cur.first);
        end else if (!active || idx >= cur.k) begin
            abort_with("Output pixel outside the expected count of a line");
        end
        pos = `STEP_ONE + idx * cur.step;
        if (!cur.is_edge && idx >= 2) begin
            assert (pix_o.data == cur.val)
                else report_mismatch("pix_o.data", 32'(pix_o.data), 32'(cur.val));
        end
        // Overshoot just past the edge must clamp to full scale
        if (cur.is_edge && pos >= (cur.edge_at + 1) * `STEP_ONE) begin
            assert (pix_o.data == PIX_FULL)
                else report_mismatch("pix_o.data", 32'(pix_o.data), 32'(PIX_FULL));
        end
        idx = idx + 1;
    endtask

    // Scoreboard and run limit, outputs sampled before this edge's updates
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT) begin
            abort_with("Timeout before all output lines arrived");
        end else if (DUT.u_checker.fail_cnt != 0) begin
            abort_with("Assertion in the bound checker failed");
        end else if (!rst_i && pix_o.de) begin
            check_output();
        end
    end

    initial begin
        void'($urandom(SEED));
        rst_i  = 1'b1;
        step_i = `STEP_W'(`STEP_ONE);
        pix_i  = '0;
        repeat (RST_CYC) @(posedge clk);
        rst_i <= 1'b0;
        for (int f = 0; f < N_FRAMES; f++) begin
            @(posedge clk);
            if (!(f > 0 && MID_CHG[f - 1])) begin
                step_i <= `STEP_W'(STEPS[f]);
            end
            send_frame(f);
        end
        wait (lines_seen == N_FRAMES * LINES_PF && idx == cur.k);
        repeat (8) @(posedge clk);
        if (DUT.u_checker.fail_cnt == 0 && lines_q.size() == 0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            stop_failed();
        end
    end

endmodule

`default_nettype wire

/* sim.f */
+incdir+rtl
rtl/scaler_pkg.sv
rtl/cubic_table.sv
rtl/scaler_h.sv
rtl/scaler_top.sv
tests/scaler_checker.sv
tests/scaler_tb.sv

/* Makefile */
# Verilator build and run of the horizontal scaler testbench

VERILATOR ?= verilator
TOP       ?= scaler_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert --timescale 1ns/1ps -Wno-fatal
# Checker assertion failures are counted, the testbench then ends the run
RUNFLAGS  ?= +verilator+error+limit+100
PASS_MSG  ?= ALL TESTS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator from $(FILELIST) and run $(TOP)"
	@echo "  clean  remove $(OBJ_DIR)"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS RUNFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUNFLAGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
